// File: Makefile
VERILATOR ?= verilator
TOP       ?= main_bus_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/main_bus_tb.sv
// testbench for the main board glue logic
// bus master, memory port model, reference values and watchdog

module main_bus_tb import arcade_pkg::*; ();

    localparam int PERIOD  = 40;
    localparam int NUM_REQ = 23;
    localparam int MAX_LAT = 8;

    logic clk, rst, req_valid, req_ready, rsp_valid, rsp_ready;
    bus_req_t req;
    bus_rsp_t rsp;
    logic mem_valid, mem_ready, mem_rvalid;
    logic [15:0] mem_addr;
    mem_tgt_e mem_tgt;
    logic [7:0] mem_rdata, dipsw_a, dipsw_b, psg_data;
    logic [3:0] dipsw_c;
    cab_in_t cab;
    logic dip_pause, lvbl, v16, irq_n, nmi_n, flip, psg_wr;
    logic [2:0] pal_sel;

    integer seed = 15485;
    int checks, errors, test_err, psg_pulses;
    logic [15:0] exp_addr;
    mem_tgt_e exp_tgt;

    main_bus_top main_bus_top_i (.*);

    always #(PERIOD / 2) clk = ~clk;

    // memory contents as a function of target and the whole address
    function automatic logic [7:0] mem_data(mem_tgt_e t, logic [15:0] a);
        return a[15:8] ^ a[7:0] ^ {t, 6'h15};
    endfunction

    function automatic logic [7:0] joy_byte(logic [5:0] j);
        return {2'b11, j[5:4], j[2], j[3], j[0], j[1]};  // board swaps the pairs
    endfunction

    task automatic check_val(string name, logic [15:0] got, logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(string name);
        $display("test %s done, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // response held until taken
    assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
        $display("response changed or dropped before it was taken at %0t", $time);
        errors++;
    end

    // no new request while a response is pending
    assert property (@(posedge clk) disable iff (rst) rsp_valid |-> !req_ready)
    else begin
        $display("req_ready high while a response was pending at %0t", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_tgt))
    else begin
        $display("memory request changed or dropped before mem_ready at %0t", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst) psg_wr |=> !psg_wr)
    else begin
        $display("psg_wr strobe longer than one cycle at %0t", $time);
        errors++;
    end

    // one request, waits for its response under random back-pressure
    task automatic bus_op(input logic [15:0] a, input logic [7:0] d, input logic rd,
                          output logic [7:0] q, output int lat);
        bus_rsp_t held;
        logic seen;
        int n;
        seen = 0;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req <= '{a, d, rd};
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b0;
        forever begin
            @(negedge clk);
            n++;
            if (rsp_valid) begin
                if (!seen) begin
                    seen = 1;
                    held = rsp;
                    lat = n - 1;
                end
                if (rsp_ready) break;
            end
        end
        q = held.rdata;
        check_val("rsp.was_read", held.was_read, rd);
        if (!rd) check_val("rsp.rdata", q, 8'hff);
    endtask

    task automatic local_read(string name, logic [15:0] a, logic [7:0] exp);
        logic [7:0] q;
        int lat;
        bus_op(a, 8'h00, 1'b1, q, lat);
        check_val(name, q, exp);
        check_val("local latency", lat, 2);
    endtask

    task automatic mem_read(logic [15:0] a, mem_tgt_e t);
        logic [7:0] q;
        int lat;
        exp_addr = a;
        exp_tgt = t;
        bus_op(a, 8'h00, 1'b1, q, lat);
        check_val("mem read rdata", q, mem_data(t, a));
    endtask

    task automatic write(logic [15:0] a, logic [7:0] d);
        logic [7:0] q;
        int lat;
        bus_op(a, d, 1'b0, q, lat);
        check_val("write latency", lat, 2);
    endtask

    always @(posedge clk) begin
        rsp_ready <= ($random(seed) & 3) != 0;
        mem_ready <= $random(seed) & 1;
    end

    always @(negedge clk) if (psg_wr) psg_pulses++;

    // memory port model with random read latency
    always begin
        int lat;
        logic [15:0] addr_l;
        mem_tgt_e tgt_l;
        @(negedge clk);
        if (mem_valid && mem_ready) begin
            addr_l = mem_addr;
            tgt_l = mem_tgt;
            check_val("mem_addr", addr_l, exp_addr);
            check_val("mem_tgt", tgt_l, exp_tgt);
            lat = 1 + ($unsigned($random(seed)) % MAX_LAT);
            repeat (lat) @(posedge clk);
            mem_rvalid <= 1'b1;
            mem_rdata <= mem_data(tgt_l, addr_l);
            @(posedge clk);
            mem_rvalid <= 1'b0;
        end
    end

    initial begin
        #(NUM_REQ * (MAX_LAT + 20) * PERIOD);
        $display("timeout: tests did not finish within the time limit");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk = 0;
        rst = 1;
        req_valid = 0;
        req = '0;
        rsp_ready = 0;
        mem_ready = 0;
        mem_rvalid = 0;
        mem_rdata = 0;
        cab = cab_in_t'($random(seed));
        dipsw_a = $random(seed);
        dipsw_b = $random(seed);
        dipsw_c = $random(seed);
        dip_pause = 1;
        lvbl = 1;
        v16 = 0;
        checks = 0;
        errors = 0;
        test_err = 0;
        psg_pulses = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("irq_n", irq_n, 1);
        check_val("nmi_n", nmi_n, 1);
        check_val("flip", flip, 0);
        check_val("pal_sel", pal_sel, 0);
        check_val("psg_wr", psg_wr, 0);
        check_val("rsp_valid", rsp_valid, 0);
        check_val("mem_valid", mem_valid, 0);
        check_val("req_ready", req_ready, 1);
        end_test("reset");

        local_read("ior sys", 16'h4e00, {3'b111, cab.start, cab.service, cab.coin});
        local_read("ior joy1", 16'h4e01, joy_byte(cab.joy1));
        local_read("ior joy2", 16'h4e02, joy_byte(cab.joy2));
        local_read("ior dipsw_a", 16'h4e03, dipsw_a);
        local_read("dip2", 16'h4c00, dipsw_b);
        local_read("dip3", 16'h4d00, {4'hf, dipsw_c});
        local_read("unmapped", 16'h7800, 8'hff);
        local_read("unmapped", 16'h4a00, 8'hff);
        end_test("local reads");

        mem_read(16'h8123, tgt_rom);
        mem_read(16'hf0a5, tgt_rom);
        mem_read(16'h5812, tgt_vram);
        mem_read(16'h5433, tgt_obj);
        mem_read(16'h5077, tgt_obj);
        end_test("memory reads");

        write(16'h4000, 8'h01);
        check_val("flip", flip, 1);
        write(16'h4f00, 8'h05);
        check_val("pal_sel", pal_sel, 3'd5);
        psg_pulses = 0;
        write(16'h4800, 8'ha5);
        write(16'h4900, 8'h00);
        check_val("psg_data", psg_data, 8'ha5);
        check_val("psg_wr pulses", psg_pulses, 1);
        local_read("busy", 16'h0000, 8'hfe);
        local_read("busy", 16'h0000, 8'hff);
        end_test("control writes");

        write(16'h4000, 8'h04);
        @(posedge clk) lvbl <= 1'b0;
        repeat (3) @(negedge clk);
        check_val("irq_n", irq_n, 0);  // set on the fall, lvbl still low
        @(posedge clk) lvbl <= 1'b1;
        repeat (2) @(negedge clk);
        check_val("irq_n", irq_n, 0);
        write(16'h4000, 8'h00);
        @(negedge clk);
        check_val("irq_n", irq_n, 1);
        write(16'h4000, 8'h02);
        @(posedge clk) v16 <= 1'b1;
        repeat (3) @(negedge clk);
        check_val("nmi_n", nmi_n, 0);
        write(16'h4000, 8'h00);
        @(posedge clk) v16 <= 1'b0;
        repeat (2) @(posedge clk);
        v16 <= 1'b1;
        repeat (3) @(negedge clk);
        check_val("nmi_n", nmi_n, 1);
        end_test("interrupts");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: rtl/arcade_pkg.sv
// bus request and response structs, chip selects
// cabinet input struct and the cabinet read word union
// external memory target encoding

package arcade_pkg;

    // one cpu bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rnw;     // 1 = read
    } bus_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       was_read;
    } bus_rsp_t;

    // one-hot, registered per transaction
    typedef struct packed {
        logic rom;
        logic vram;
        logic obj1;
        logic obj2;
        logic iow;       // control write
        logic ior;       // cabinet inputs
        logic dip2;
        logic dip3;
        logic psg_data;  // sound data latch
        logic psg_wr;    // sound strobe
        logic pal;
        logic busy;      // speech busy status
    } chip_sel_t;

    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic [5:0] joy1;
        logic [5:0] joy2;
    } cab_in_t;

    typedef struct packed {
        logic [2:0] fill;
        logic [1:0] start;
        logic       service;
        logic [1:0] coin;
    } cab_sys_t;

    typedef struct packed {
        logic [1:0] fill;
        logic [1:0] buttons;
        logic       down;
        logic       up;
        logic       left;
        logic       right;
    } cab_joy_t;

    // same ior byte, laid out two ways
    typedef union packed {
        cab_sys_t sys;
        cab_joy_t joy;
    } cab_word_u;

    typedef enum logic [1:0] {
        tgt_rom  = 2'd0,
        tgt_vram = 2'd1,
        tgt_obj  = 2'd2
    } mem_tgt_e;

endpackage

// File: rtl/bus_decoder.sv
// request acceptance and address decode
// registered request and one-hot chip selects

module bus_decoder import arcade_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  bus_req_t  req,
    input  logic      txn_done,
    output logic      txn_go,
    output bus_req_t  txn,
    output chip_sel_t cs
);

    logic      busy;
    logic      accept;
    chip_sel_t dec;

    assign req_ready = ~busy;
    assign accept    = req_valid & req_ready;

    always_comb begin
        dec = '0;
        case (req.addr[15:14])
            2'd0: dec.busy = 1'b1;
            2'd1: begin
                case (req.addr[13:11])
                    3'd0: dec.iow = 1'b1;
                    3'd1: begin
                        case (req.addr[10:8])
                            3'd7: dec.pal      = 1'b1;
                            3'd6: dec.ior      = 1'b1;
                            3'd5: dec.dip3     = 1'b1;
                            3'd4: dec.dip2     = 1'b1;
                            3'd1: dec.psg_wr   = 1'b1;
                            3'd0: dec.psg_data = 1'b1;
                            default: ;
                        endcase
                    end
                    3'd2: {dec.obj2, dec.obj1} = {~req.addr[10], req.addr[10]};
                    3'd3: dec.vram = 1'b1;
                    default: ;
                endcase
            end
            default: dec.rom = req.rnw;  // rom is read only
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            txn_go <= 1'b0;
            cs     <= '0;
        end else begin
            txn_go <= accept;
            if (accept) begin
                busy <= 1'b1;
                cs   <= dec;
            end else if (txn_done) begin
                busy <= 1'b0;
            end
        end
    end

    // accepted request payload
    always_ff @(posedge clk) begin
        if (accept) txn <= req;
    end

endmodule

// File: rtl/cabinet_port.sv
// local read data for cabinet inputs, dip switches
// and the speech busy status

module cabinet_port import arcade_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       txn_go,
    input  bus_req_t   txn,
    input  chip_sel_t  cs,
    input  cab_in_t    cab,
    input  logic [7:0] dipsw_a,
    input  logic [7:0] dipsw_b,
    input  logic [3:0] dipsw_c,
    output logic [7:0] loc_rdata
);

    cab_word_u cab_word;
    logic      bsy_tgl;   // fake speech busy

    // ior byte picked by the low address bits
    always_comb begin
        cab_word = '1;
        case (txn.addr[1:0])
            2'd0: begin
                cab_word.sys.fill    = 3'b111;
                cab_word.sys.start   = cab.start;
                cab_word.sys.service = cab.service;
                cab_word.sys.coin    = cab.coin;
            end
            2'd1: begin
                cab_word.joy.fill    = 2'b11;
                cab_word.joy.buttons = cab.joy1[5:4];
                cab_word.joy.down    = cab.joy1[2];  // swapped on the board
                cab_word.joy.up      = cab.joy1[3];
                cab_word.joy.left    = cab.joy1[0];
                cab_word.joy.right   = cab.joy1[1];
            end
            2'd2: begin
                cab_word.joy.fill    = 2'b11;
                cab_word.joy.buttons = cab.joy2[5:4];
                cab_word.joy.down    = cab.joy2[2];
                cab_word.joy.up      = cab.joy2[3];
                cab_word.joy.left    = cab.joy2[0];
                cab_word.joy.right   = cab.joy2[1];
            end
            default: cab_word = dipsw_a;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bsy_tgl <= 1'b0;
        end else if (txn_go && cs.busy && txn.rnw) begin
            bsy_tgl <= ~bsy_tgl;
        end
    end

    always_ff @(posedge clk) begin
        if (txn_go) begin
            if (cs.ior)       loc_rdata <= cab_word;
            else if (cs.dip2) loc_rdata <= dipsw_b;
            else if (cs.dip3) loc_rdata <= {4'hf, dipsw_c};
            else if (cs.busy) loc_rdata <= {7'h7f, bsy_tgl};
            else              loc_rdata <= 8'hff;
        end
    end

endmodule

// File: rtl/main_bus_top.sv
// main board glue logic top level
// decoder, cabinet port, system control and read merge

module main_bus_top import arcade_pkg::*; #(
    parameter int IRQ_ON_FALL = 1,
    parameter int PAL_W       = 3
) (
    input  logic             clk,
    input  logic             rst,
    // cpu request channel
    input  logic             req_valid,
    output logic             req_ready,
    input  bus_req_t         req,
    // response channel
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output bus_rsp_t         rsp,
    // external memory port
    output logic             mem_valid,
    input  logic             mem_ready,
    output logic [15:0]      mem_addr,
    output mem_tgt_e         mem_tgt,
    input  logic             mem_rvalid,
    input  logic [7:0]       mem_rdata,
    // cabinet and dips
    input  cab_in_t          cab,
    input  logic [7:0]       dipsw_a,
    input  logic [7:0]       dipsw_b,
    input  logic [3:0]       dipsw_c,
    input  logic             dip_pause,
    // video timing
    input  logic             lvbl,
    input  logic             v16,
    output logic             irq_n,
    output logic             nmi_n,
    output logic             flip,
    output logic [PAL_W-1:0] pal_sel,
    // sound chip
    output logic [7:0]       psg_data,
    output logic             psg_wr
);

    logic      txn_go;
    logic      txn_done;
    bus_req_t  txn;
    chip_sel_t cs;
    logic [7:0] loc_rdata;

    bus_decoder u_dec (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .txn_done  (txn_done),
        .txn_go    (txn_go),
        .txn       (txn),
        .cs        (cs)
    );

    cabinet_port u_cab (
        .clk       (clk),
        .rst       (rst),
        .txn_go    (txn_go),
        .txn       (txn),
        .cs        (cs),
        .cab       (cab),
        .dipsw_a   (dipsw_a),
        .dipsw_b   (dipsw_b),
        .dipsw_c   (dipsw_c),
        .loc_rdata (loc_rdata)
    );

    sys_ctrl #(
        .IRQ_ON_FALL (IRQ_ON_FALL),
        .PAL_W       (PAL_W)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .txn_go    (txn_go),
        .txn       (txn),
        .cs        (cs),
        .lvbl      (lvbl),
        .v16       (v16),
        .dip_pause (dip_pause),
        .irq_n     (irq_n),
        .nmi_n     (nmi_n),
        .flip      (flip),
        .pal_sel   (pal_sel),
        .psg_data  (psg_data),
        .psg_wr    (psg_wr)
    );

    read_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .txn_go     (txn_go),
        .txn        (txn),
        .cs         (cs),
        .loc_rdata  (loc_rdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_tgt    (mem_tgt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .txn_done   (txn_done)
    );

endmodule

// File: rtl/read_merge.sv
// external memory read sequencing
// merges local and memory data into one bus response

module read_merge import arcade_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       txn_go,
    input  bus_req_t   txn,
    input  chip_sel_t  cs,
    input  logic [7:0] loc_rdata,
    output logic       mem_valid,
    input  logic       mem_ready,
    output logic [15:0] mem_addr,
    output mem_tgt_e   mem_tgt,
    input  logic       mem_rvalid,
    input  logic [7:0] mem_rdata,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output bus_rsp_t   rsp,
    output logic       txn_done
);

    typedef enum logic [2:0] {
        st_idle,
        st_local,
        st_mem_req,
        st_mem_wait,
        st_respond
    } state_e;

    state_e state;
    logic   mem_rd;
    logic   loc_hit;

    assign mem_rd  = txn.rnw & (cs.rom | cs.vram | cs.obj1 | cs.obj2);
    assign loc_hit = txn.rnw & (cs.ior | cs.dip2 | cs.dip3 | cs.busy);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            mem_valid <= 1'b0;
            rsp_valid <= 1'b0;
            txn_done  <= 1'b0;
        end else begin
            txn_done <= 1'b0;
            case (state)
                st_idle: if (txn_go) begin
                    if (mem_rd) begin
                        state     <= st_mem_req;
                        mem_valid <= 1'b1;
                    end else begin
                        state <= st_local;  // loc_rdata ready next cycle
                    end
                end
                st_local: begin
                    rsp_valid <= 1'b1;
                    state     <= st_respond;
                end
                st_mem_req: if (mem_ready) begin
                    mem_valid <= 1'b0;
                    state     <= st_mem_wait;
                end
                st_mem_wait: if (mem_rvalid) begin
                    rsp_valid <= 1'b1;
                    state     <= st_respond;
                end
                st_respond: if (rsp_ready) begin
                    rsp_valid <= 1'b0;
                    txn_done  <= 1'b1;   // frees the decoder
                    state     <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == st_idle && txn_go) begin
            mem_addr <= txn.addr;
            if (cs.rom)       mem_tgt <= tgt_rom;
            else if (cs.vram) mem_tgt <= tgt_vram;
            else              mem_tgt <= tgt_obj;
        end
        if (state == st_local) begin
            rsp.rdata    <= loc_hit ? loc_rdata : 8'hff;  // writes, unmapped read ff
            rsp.was_read <= txn.rnw;
        end
        if (state == st_mem_wait && mem_rvalid) begin
            rsp.rdata    <= mem_rdata;
            rsp.was_read <= 1'b1;
        end
    end

endmodule

// File: rtl/sys_ctrl.sv
// control register, palette bank, sound data latch and strobe
// edge triggered irq and nmi latches

module sys_ctrl import arcade_pkg::*; #(
    parameter int IRQ_ON_FALL = 1,
    parameter int PAL_W       = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             txn_go,
    input  bus_req_t         txn,
    input  chip_sel_t        cs,
    input  logic             lvbl,
    input  logic             v16,
    input  logic             dip_pause,
    output logic             irq_n,
    output logic             nmi_n,
    output logic             flip,
    output logic [PAL_W-1:0] pal_sel,
    output logic [7:0]       psg_data,
    output logic             psg_wr
);

    logic wr;
    logic iow_wr;
    logic irq_en, nmi_en;
    logic lvbl_l, v16_l;
    logic vbl_edge, v16_edge;

    assign wr     = txn_go & ~txn.rnw;
    assign iow_wr = wr & cs.iow;

    // vblank edge polarity set by the top level
    assign vbl_edge = (IRQ_ON_FALL != 0) ? (lvbl_l & ~lvbl) : (~lvbl_l & lvbl);
    assign v16_edge = ~v16_l & v16;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            irq_en  <= 1'b0;
            nmi_en  <= 1'b0;
            flip    <= 1'b0;
            pal_sel <= '0;
            psg_wr  <= 1'b0;
        end else begin
            psg_wr <= wr & cs.psg_wr;  // single cycle strobe
            if (iow_wr) begin
                irq_en <= txn.wdata[2];
                nmi_en <= txn.wdata[1];
                flip   <= txn.wdata[0];
            end
            if (wr && cs.pal) pal_sel <= txn.wdata[PAL_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr && cs.psg_data) psg_data <= txn.wdata;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b1;
            v16_l  <= 1'b0;
            irq_n  <= 1'b1;
            nmi_n  <= 1'b1;
        end else begin
            lvbl_l <= lvbl;
            v16_l  <= v16;
            if (iow_wr && !txn.wdata[2])
                irq_n <= 1'b1;  // disabling also acknowledges
            else if (irq_en && dip_pause && vbl_edge)
                irq_n <= 1'b0;
            if (iow_wr && !txn.wdata[1])
                nmi_n <= 1'b1;
            else if (nmi_en && v16_edge)
                nmi_n <= 1'b0;
        end
    end

endmodule

// File: src.f
rtl/arcade_pkg.sv
rtl/bus_decoder.sv
rtl/cabinet_port.sv
rtl/sys_ctrl.sv
rtl/read_merge.sv
rtl/main_bus_top.sv
bench/main_bus_tb.sv
